/* compile.f */
verilog/usiBusPkg.sv
verilog/usiTimeoutTimer.sv
verilog/usiCommandFsm.sv
verilog/microControllerCsr.sv
verilog/usiSlaveRegs.sv
verilog/microControllerBlock.sv
verification/microControllerBlockTb.sv

/* run.sh */
#!/bin/sh
# Build and run the bus-master testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module microControllerBlockTb \
	-Mdir obj_dir

output=$(./obj_dir/VmicroControllerBlockTb)
echo "$output"

# Pass only when the testbench reports it
if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1

/* verification/microControllerBlockTb.sv */
// Testbench for the bus-master subsystem
// Stimulus table with LCG write data and a register shadow model
// Immediate-assertion checks and a closing error summary

`timescale 1ns/10ps

module microControllerBlockTb;

	import usiBusPkg::*;

	// What to check on the response of one step
	typedef enum logic [1:0]
	{
		ckWriteResp,
		ckReadShadow,
		ckReadSig,
		ckReadTimeout
	} checkKindE;

	// One table entry
	typedef struct packed
	{
		usiOpE       op;
		logic [3:0]  slaveId;
		logic [1:0]  regOfs;
		logic [31:0] data;
		checkKindE   kind;
	} stepT;

	// Bound on every wait, in clock cycles
	localparam int waitLimit = 100;
	// Acceptance edge to respValid for writes
	localparam int writeLatency = 2;
	// Slaves fitted in the default top
	localparam int slaveCount = 2;

	logic     sysClk;
	logic     rstN;
	hostCmdT  hostCmd;
	logic     hostValid;
	logic     hostReady;
	hostRespT hostResp;
	logic     respValid;

	stepT        steps[$];
	logic [31:0] shadow [slaveCount][3];
	logic [31:0] lcgState;
	int          errors;
	bit          hung;

	microControllerBlock microControllerBlock_inst (
		.sysClk(sysClk),
		.rstN(rstN),
		.hostCmd(hostCmd),
		.hostValid(hostValid),
		.hostReady(hostReady),
		.hostResp(hostResp),
		.respValid(respValid)
	);

	// 8 ns clock
	initial
	begin
		sysClk = 1'b0;
		forever #4 sysClk = ~sysClk;
	end

	//----------------------------------------
	// Stimulus table
	//----------------------------------------
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Write data drawn at build time
	function automatic void addStep(usiOpE op, int slaveId, int regOfs, checkKindE kind);
		stepT s;
		s.op = op;
		s.slaveId = 4'(slaveId);
		s.regOfs = 2'(regOfs);
		s.data = (op == opWrite) ? nextRandom() : 32'd0;
		s.kind = kind;
		steps.push_back(s);
	endfunction

	function automatic void buildTable();
		// Fresh from reset, all zero
		for (int sid = 0; sid < slaveCount; sid++)
			for (int ofs = 0; ofs < 3; ofs++)
				addStep(opRead, sid, ofs, ckReadShadow);
		// Fill both slaves
		for (int sid = 0; sid < slaveCount; sid++)
			for (int ofs = 0; ofs < 3; ofs++)
				addStep(opWrite, sid, ofs, ckWriteResp);
		// Read back, other slave untouched
		for (int sid = 0; sid < slaveCount; sid++)
			for (int ofs = 0; ofs < 3; ofs++)
				addStep(opRead, sid, ofs, ckReadShadow);
		// Overwrite on slave 1 only
		addStep(opWrite, 1, 1, ckWriteResp);
		addStep(opRead, 0, 1, ckReadShadow);
		addStep(opRead, 1, 1, ckReadShadow);
		// Identity word ignores writes
		addStep(opWrite, 0, 3, ckWriteResp);
		addStep(opWrite, 1, 3, ckWriteResp);
		addStep(opRead, 0, 3, ckReadSig);
		addStep(opRead, 1, 3, ckReadSig);
		// Absent slave 5
		addStep(opRead, 5, 0, ckReadTimeout);
		addStep(opWrite, 5, 2, ckWriteResp);
		addStep(opRead, 5, 3, ckReadTimeout);
		// Bus still healthy after a timeout
		addStep(opRead, 0, 0, ckReadShadow);
	endfunction

	//----------------------------------------
	// Checks and one host transaction
	//----------------------------------------
	task automatic checkValue(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
		end
	endtask

	task automatic runStep(input int idx);
		stepT        s;
		checkKindE   kind;
		string       name;
		hostRespT    resp;
		int          sid;
		int          ofs;
		int          cycles;
		bit          readyOk;
		s = steps[idx];
		kind = s.kind;
		sid = int'(s.slaveId);
		ofs = int'(s.regOfs);
		name = $sformatf("%s#%0d s%0d o%0d", kind.name(), idx, sid, ofs);
		// Wait until the DUT takes a command
		cycles = 0;
		while (!hostReady && cycles < waitLimit)
		begin
			@(posedge sysClk);
			#1;
			cycles++;
		end
		assert (hostReady)
		else
		begin
			errors++;
			hung = 1'b1;
			$display("Timeout: hostReady never rose before %s", name);
		end
		if (hung)
			return;
		hostCmd = '{op: s.op, slaveId: s.slaveId, regOfs: s.regOfs, wd: s.data};
		hostValid = 1'b1;
		// Acceptance edge
		@(posedge sysClk);
		#1;
		hostValid = 1'b0;
		readyOk = !hostReady;
		// Count edges up to the response strobe
		cycles = 0;
		while (!respValid && cycles < waitLimit)
		begin
			@(posedge sysClk);
			#1;
			cycles++;
			if (hostReady)
				readyOk = 1'b0;
		end
		assert (respValid)
		else
		begin
			errors++;
			hung = 1'b1;
			$display("Timeout: no response for %s", name);
		end
		if (hung)
			return;
		resp = hostResp;
		assert (readyOk)
		else
		begin
			errors++;
			$display("hostReady rose while %s was still in flight", name);
		end
		case (kind)
			ckWriteResp:
			begin
				checkValue(name, "latency", 32'(writeLatency), 32'(cycles));
				checkValue(name, "rd", 32'd0, resp.rd);
				checkValue(name, "timeout", 32'd0, 32'(resp.timeout));
				// Only present slaves and read/write offsets keep data
				if (sid < slaveCount && ofs < 3)
					shadow[sid][ofs] = s.data;
			end
			ckReadShadow:
			begin
				checkValue(name, "rd", shadow[sid][ofs], resp.rd);
				checkValue(name, "timeout", 32'd0, 32'(resp.timeout));
			end
			ckReadSig:
			begin
				checkValue(name, "rd", {slaveSignature, 16'(sid)}, resp.rd);
				checkValue(name, "timeout", 32'd0, 32'(resp.timeout));
			end
			default:
			begin
				checkValue(name, "rd", 32'd0, resp.rd);
				checkValue(name, "timeout", 32'd1, 32'(resp.timeout));
			end
		endcase
	endtask

	//----------------------------------------
	// Main sequence
	//----------------------------------------
	initial
	begin
		errors = 0;
		hung = 1'b0;
		lcgState = 32'd34;
		rstN = 1'b0;
		hostValid = 1'b0;
		hostCmd = '0;
		for (int sid = 0; sid < slaveCount; sid++)
			for (int ofs = 0; ofs < 3; ofs++)
				shadow[sid][ofs] = 32'd0;
		buildTable();
		repeat (8) @(posedge sysClk);
		#1;
		rstN = 1'b1;
		// Stop walking the table once the DUT stops answering
		for (int i = 0; i < steps.size() && !hung; i++)
			runStep(i);
		$display("Run finished with %0d error(s) over %0d steps", errors, steps.size());
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verilog/microControllerBlock.sv */
// Bus-master subsystem top
// Command FSM, read timer, bus drive stage and the register slaves

`timescale 1ns/10ps

module microControllerBlock #(
	parameter int pBusBlockConnect = 2,
	parameter int pSlaveLatency    = 3,
	parameter int pTimeoutCycles   = 16
)(
	input  logic                sysClk,
	input  logic                rstN,
	input  usiBusPkg::hostCmdT  hostCmd,
	input  logic                hostValid,
	output logic                hostReady,
	output usiBusPkg::hostRespT hostResp,
	output logic                respValid
);

	import usiBusPkg::*;

	hostCmdT                     cmdLatched;
	usiMasterT                   usiBus;
	logic                        issuePulse;
	logic                        readHit;
	logic                        timerStart;
	logic                        expired;
	logic [busDataBit-1:0]       capturedRd;
	logic [busDataBit-1:0]       slaveRd;
	logic [pBusBlockConnect-1:0] slaveREd;
	logic [busDataBit-1:0]       slaveRdArr [pBusBlockConnect];

	//----------------------------------------
	// Master side
	//----------------------------------------
	usiCommandFsm usiCommandFsm_inst (
		.sysClk(sysClk), .rstN(rstN),
		.hostCmd(hostCmd), .hostValid(hostValid), .hostReady(hostReady),
		.issuePulse(issuePulse), .cmdLatched(cmdLatched),
		.readHit(readHit), .capturedRd(capturedRd),
		.timerStart(timerStart), .expired(expired),
		.hostResp(hostResp), .respValid(respValid)
	);

	// An answer stops the timer
	usiTimeoutTimer #(.pTimeoutCycles(pTimeoutCycles)) usiTimeoutTimer_inst (
		.sysClk(sysClk), .rstN(rstN),
		.timerStart(timerStart), .timerStop(readHit), .expired(expired)
	);

	microControllerCsr #(.pBusBlockConnect(pBusBlockConnect)) microControllerCsr_inst (
		.sysClk(sysClk), .rstN(rstN),
		.issuePulse(issuePulse), .cmdLatched(cmdLatched), .usiBus(usiBus),
		.slaveRd(slaveRd), .slaveREd(slaveREd),
		.readHit(readHit), .capturedRd(capturedRd)
	);

	//----------------------------------------
	// Slaves, id equals bus position
	//----------------------------------------
	for (genvar gi = 0; gi < pBusBlockConnect; gi++)
	begin : gSlave
		usiSlaveRegs #(.pSlaveId(gi), .pSlaveLatency(pSlaveLatency)) usiSlaveRegs_inst (
			.sysClk(sysClk), .rstN(rstN), .usiBus(usiBus),
			.rd(slaveRdArr[gi]), .rEd(slaveREd[gi])
		);
	end

	// Idle slaves drive zero
	always_comb
	begin
		slaveRd = '0;
		for (int i = 0; i < pBusBlockConnect; i++)
			slaveRd = slaveRd | slaveRdArr[i];
	end

endmodule

/* verilog/usiSlaveRegs.sv */
// USI register slave
// Three read/write registers and a read-only identity word
// Read answers come back after a fixed latency with a one-cycle rEd

`timescale 1ns/10ps

module usiSlaveRegs #(
	parameter int pSlaveId      = 0,
	parameter int pSlaveLatency = 3
)(
	input  logic                 sysClk,
	input  logic                 rstN,
	input  usiBusPkg::usiMasterT usiBus,
	output logic [31:0]          rd,
	output logic                 rEd
);

	import usiBusPkg::*;

	localparam int cntBit = $clog2(pSlaveLatency + 1);

	logic [busDataBit-1:0] regFile [3];
	logic [slaveIdBit-1:0] adrsId;
	logic [regOfsBit-1:0]  adrsOfs;
	logic                  idHit;
	logic                  wrHit;
	logic                  rdCmd;
	logic                  busy;
	logic [cntBit-1:0]     latCnt;
	logic [regOfsBit-1:0]  rdOfs;
	logic [busDataBit-1:0] rdVal;

	//----------------------------------------
	// Address decode
	//----------------------------------------
	assign adrsId = usiBus.adrs[adrsIdLsb +: slaveIdBit];
	assign adrsOfs = usiBus.adrs[regOfsBit-1:0];
	assign idHit = usiBus.wEd && (adrsId == slaveIdBit'(pSlaveId));
	assign wrHit = idHit && !usiBus.adrs[adrsReadBit];
	assign rdCmd = idHit && usiBus.adrs[adrsReadBit];

	// Writes to offset 3 match no entry and drop
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 3; i++)
				regFile[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < 3; i++)
				if (wrHit && (adrsOfs == regOfsBit'(i)))
					regFile[i] <= usiBus.wd;
		end
	end

	//----------------------------------------
	// Read latency
	//----------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			latCnt <= '0;
		end
		else if (!busy)
		begin
			if (rdCmd)
			begin
				busy <= 1'b1;
				latCnt <= cntBit'(pSlaveLatency - 1);
			end
		end
		// Reads arriving while busy are ignored
		else if (latCnt == '0)
			busy <= 1'b0;
		else
			latCnt <= latCnt - 1'b1;
	end

	// Offset held for the answer cycle
	always_ff @(posedge sysClk)
	begin
		if (rdCmd && !busy)
			rdOfs <= adrsOfs;
	end

	always_comb
	begin
		case (rdOfs)
			2'd0: rdVal = regFile[0];
			2'd1: rdVal = regFile[1];
			2'd2: rdVal = regFile[2];
			default: rdVal = {slaveSignature, 16'(pSlaveId)};
		endcase
	end

	// Drive zero outside the answer cycle so the top can OR
	assign rEd = busy && (latCnt == '0);
	assign rd = rEd ? rdVal : '0;

endmodule

/* verilog/microControllerCsr.sv */
// Bus drive and read capture stage
// Packs the latched command into the USI address field, registers the drive
// and selects the read answer from the slave read-enables

`timescale 1ns/10ps

module microControllerCsr #(
	parameter int pBusBlockConnect = 2
)(
	input  logic                        sysClk,
	input  logic                        rstN,
	// From FSM
	input  logic                        issuePulse,
	input  usiBusPkg::hostCmdT          cmdLatched,
	// USI bus master drive
	output usiBusPkg::usiMasterT        usiBus,
	// Slave answers
	input  logic [31:0]                 slaveRd,
	input  logic [pBusBlockConnect-1:0] slaveREd,
	// Back to FSM
	output logic                        readHit,
	output logic [31:0]                 capturedRd
);

	import usiBusPkg::*;

	logic [busAdrsBit-1:0] nextAdrs;
	logic [busDataBit-1:0] busWd;
	logic [busAdrsBit-1:0] busAdrs;
	logic                  busWEd;
	logic                  readPending;
	logic                  anyREd;

	//----------------------------------------
	// Address/command packing
	//----------------------------------------
	always_comb
	begin
		// Unused middle bits stay zero
		nextAdrs = '0;
		nextAdrs[adrsReadBit] = (cmdLatched.op == opRead);
		nextAdrs[adrsIdLsb +: slaveIdBit] = cmdLatched.slaveId;
		nextAdrs[regOfsBit-1:0] = cmdLatched.regOfs;
	end

	// Payload, only sampled by slaves under wEd
	always_ff @(posedge sysClk)
	begin
		if (issuePulse)
		begin
			busAdrs <= nextAdrs;
			// Reads carry no data
			busWd <= (cmdLatched.op == opWrite) ? cmdLatched.wd : '0;
		end
	end

	// Strobe and outstanding-read flag
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			busWEd <= 1'b0;
			readPending <= 1'b0;
		end
		else
		begin
			// One-cycle strobe, one cycle after issue
			busWEd <= issuePulse;
			if (issuePulse)
				readPending <= (cmdLatched.op == opRead);
			else if (readHit)
				readPending <= 1'b0;
		end
	end

	assign usiBus = '{wd: busWd, adrs: busAdrs, wEd: busWEd};

	//----------------------------------------
	// Read capture
	//----------------------------------------
	assign anyREd = |slaveREd;
	// Answers only count against an outstanding read
	assign readHit = readPending && anyREd;
	assign capturedRd = readHit ? slaveRd : '0;

	// At most one slave answers at a time
	assert property (@(posedge sysClk) disable iff (!rstN) $onehot0(slaveREd))
		else $error("slaveREd not one-hot");

	// Slaves never answer without a read on the bus
	assert property (@(posedge sysClk) disable iff (!rstN) anyREd |-> readPending)
		else $error("read-enable without a pending read");

endmodule

/* verilog/usiCommandFsm.sv */
// Host command FSM
// Latches one command, issues it to the bus stage, waits for the answer
// or the timer, and returns a single-cycle response

`timescale 1ns/10ps

module usiCommandFsm
(
	input  logic               sysClk,
	input  logic               rstN,
	// Host side
	input  usiBusPkg::hostCmdT hostCmd,
	input  logic               hostValid,
	output logic               hostReady,
	// Bus stage side
	output logic               issuePulse,
	output usiBusPkg::hostCmdT cmdLatched,
	input  logic               readHit,
	input  logic [31:0]        capturedRd,
	// Timer side
	output logic               timerStart,
	input  logic               expired,
	// Response
	output usiBusPkg::hostRespT hostResp,
	output logic               respValid
);

	import usiBusPkg::*;

	usiStateE state;
	logic     accept;

	// Ready only while idle and not in the response cycle
	assign hostReady = (state == stIdle) && !respValid;
	assign accept = hostValid && hostReady;

	// Bus stage loads the latched command during stIssue
	assign issuePulse = (state == stIssue);
	// Timer runs for reads only
	assign timerStart = issuePulse && (cmdLatched.op == opRead);

	//----------------------------------------
	// State and response strobe
	//----------------------------------------
	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			respValid <= 1'b0;
		end
		else
		begin
			respValid <= 1'b0;
			case (state)
				stIdle:
					if (accept)
						state <= stIssue;
				stIssue:
					// Writes need no answer from the slave
					if (cmdLatched.op == opWrite)
						state <= stRespond;
					else
						state <= stWaitRead;
				stWaitRead:
					if (readHit || expired)
					begin
						respValid <= 1'b1;
						state <= stIdle;
					end
				stRespond:
				begin
					respValid <= 1'b1;
					state <= stIdle;
				end
				default:
					state <= stIdle;
			endcase
		end
	end

	//----------------------------------------
	// Command and response payload
	//----------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (accept)
			cmdLatched <= hostCmd;
		case (state)
			stRespond:
				hostResp <= '{rd: '0, timeout: 1'b0};
			stWaitRead:
				// Answer wins over a same-cycle expiry
				if (readHit)
					hostResp <= '{rd: capturedRd, timeout: 1'b0};
				else if (expired)
					hostResp <= '{rd: '0, timeout: 1'b1};
			default:
				;
		endcase
	end

	// Response strobe is always a single cycle
	assert property (@(posedge sysClk) disable iff (!rstN) respValid |=> !respValid)
		else $error("respValid held for two cycles");

endmodule

/* verilog/usiTimeoutTimer.sv */
// Read timeout timer
// Loads on start, counts down while armed, pulses expired at zero

`timescale 1ns/10ps

module usiTimeoutTimer #(
	parameter int pTimeoutCycles = 16
)(
	input  logic sysClk,
	input  logic rstN,
	input  logic timerStart,
	input  logic timerStop,
	output logic expired
);

	localparam int cntBit = $clog2(pTimeoutCycles + 1);

	logic              armed;
	logic [cntBit-1:0] count;

	always_ff @(posedge sysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			armed <= 1'b0;
			count <= '0;
			expired <= 1'b0;
		end
		else
		begin
			expired <= 1'b0;
			if (timerStart)
			begin
				armed <= 1'b1;
				count <= cntBit'(pTimeoutCycles - 1);
			end
			else if (timerStop)
				armed <= 1'b0;
			else if (armed)
			begin
				// Last count, fire once and disarm
				if (count == '0)
				begin
					expired <= 1'b1;
					armed <= 1'b0;
				end
				else
					count <= count - 1'b1;
			end
		end
	end

	// Expiry only comes from a running, unstopped count
	assert property (@(posedge sysClk) disable iff (!rstN)
		expired |-> $past(armed && !timerStop && !timerStart))
		else $error("expired while timer disarmed");

endmodule

/* verilog/usiBusPkg.sv */
// USI bus package
// Address field widths and positions, opcode and FSM state enums
// Host command/response structs and the master bus drive struct

package usiBusPkg;

	//----------------------------------------
	// Field widths and positions
	//----------------------------------------
	// Data path width, shared by host and bus
	localparam int busDataBit = 32;
	// Full USI address field
	localparam int busAdrsBit = 16;
	// Slave select, up to 16 slaves
	localparam int slaveIdBit = 4;
	// Register offset inside one slave
	localparam int regOfsBit = 2;
	// Top address bit doubles as the read command
	localparam int adrsReadBit = busAdrsBit - 1;
	// Slave id sits just above the offset
	localparam int adrsIdLsb = regOfsBit;

	// Upper half of every slave identity word
	localparam logic [15:0] slaveSignature = 16'hA5C3;

	//----------------------------------------
	// Enums
	//----------------------------------------
	// Host opcode
	typedef enum logic
	{
		opWrite,
		opRead
	} usiOpE;

	// Command FSM states
	typedef enum logic [1:0]
	{
		stIdle,
		stIssue,
		stWaitRead,
		stRespond
	} usiStateE;

	//----------------------------------------
	// Structs
	//----------------------------------------
	// One host command, 39 bits
	typedef struct packed
	{
		usiOpE                  op;
		logic [slaveIdBit-1:0]  slaveId;
		logic [regOfsBit-1:0]   regOfs;
		logic [busDataBit-1:0]  wd;
	} hostCmdT;

	// Host response, rd is zero on timeout
	typedef struct packed
	{
		logic [busDataBit-1:0]  rd;
		logic                   timeout;
	} hostRespT;

	// Master drive toward all slaves, 49 bits
	typedef struct packed
	{
		logic [busDataBit-1:0]  wd;
		logic [busAdrsBit-1:0]  adrs;
		logic                   wEd;
	} usiMasterT;

endpackage
